/* fptosi.f */
+incdir+include
verilog/fptosi_pkg.sv
verilog/fp_unpack.sv
verilog/fp_int_convert.sv
verilog/delay_buffer.sv
verilog/oehb.sv
verilog/fptosi.sv
test/fptosi_tb.sv

/* Bender.yml */
package:
  name: fptosi

sources:
  # Design, package first
  - files:
      - verilog/fptosi_pkg.sv
      - verilog/fp_unpack.sv
      - verilog/fp_int_convert.sv
      - verilog/delay_buffer.sv
      - verilog/oehb.sv
      - verilog/fptosi.sv

  # Testbench with its model header
  - target: test
    include_dirs:
      - include
    files:
      - test/fptosi_tb.sv

/* include/fptosi_model.svh */
`ifndef FPTOSI_MODEL_SVH
`define FPTOSI_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model, truncation toward zero with saturation
// ----------------------------------------------------------------------
function automatic logic [31:0] fptosi_model(input logic [31:0] f);
    logic        s;
    int          e;
    logic [31:0] mag;
    s   = f[31];
    e   = int'(f[30:23]) - fptosi_pkg::EXP_BIAS;
    mag = {8'h00, 1'b1, f[22:0]};
    // Zero and subnormals
    if (f[30:23] == 8'h00) return '0;
    // Too large, inf and NaN
    if (e > fptosi_pkg::MAX_EXP) return s ? fptosi_pkg::INT_MIN : fptosi_pkg::INT_MAX;
    // Below one
    if (e < 0) return '0;
    if (e >= fptosi_pkg::FRAC_W) mag = mag << (e - fptosi_pkg::FRAC_W);
    else mag = mag >> (fptosi_pkg::FRAC_W - e);
    return s ? -mag : mag;
endfunction

// In-range value with random fraction bits
function automatic logic [31:0] gen_in_range();
    int e;
    e = $urandom_range(fptosi_pkg::MAX_EXP, 0);
    return {1'($urandom()), 8'(e + fptosi_pkg::EXP_BIAS), 23'($urandom())};
endfunction

// Zeros, subnormals and magnitudes below one
function automatic logic [31:0] gen_small();
    case ($urandom_range(3, 0))
        0: return 32'h0000_0000;
        1: return 32'h8000_0000;
        2: return {1'($urandom()), 8'h00, 23'($urandom()) | 23'd1};
        default: return {1'($urandom()), 8'($urandom_range(126, 1)), 23'($urandom())};
    endcase
endfunction

// Saturation boundary, infinities and NaNs
function automatic logic [31:0] gen_edge();
    case ($urandom_range(6, 0))
        0: return 32'h4F00_0000;
        1: return 32'hCF00_0000;
        2: return 32'h4E80_0000;
        3: return 32'hCE80_0000;
        4: return 32'h7F80_0000;
        5: return 32'hFF80_0000;
        default: return {1'($urandom()), 8'hFF, 23'($urandom()) | 23'd1};
    endcase
endfunction

// Weighted mix of all operand kinds
function automatic logic [31:0] gen_operand();
    int pick;
    pick = $urandom_range(9, 0);
    if (pick < 2) return $urandom();
    if (pick < 6) return gen_in_range();
    if (pick < 8) return gen_small();
    return gen_edge();
endfunction

`endif

/* test/fptosi_tb.sv */
module fptosi_tb;

    // ----------------------------------------------------------------------
    // Run length and timing
    // ----------------------------------------------------------------------
    localparam int N_OPS      = 2000;
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;

    // Budget of 20 cycles per operation
    localparam longint TIMEOUT = longint'(N_OPS + RST_CYCLES) * 20 * CLK_PERIOD;

    logic                         clk;
    logic                         rst;
    logic [fptosi_pkg::WIDTH-1:0] ins;
    logic                         ins_valid;
    logic                         ins_ready;
    logic [fptosi_pkg::WIDTH-1:0] outs;
    logic                         outs_valid;
    logic                         outs_ready;

    // Scoreboard, oldest expected result at the front
    logic [fptosi_pkg::WIDTH-1:0] expected [$];

    // Handshake bookkeeping between cycles
    int                           sent;
    logic                         hold_in;
    logic                         stalled;
    logic [fptosi_pkg::WIDTH-1:0] held_outs;

    `include "fptosi_model.svh"

    fptosi DUT (
        .clk        (clk),
        .rst        (rst),
        .ins        (ins),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .outs       (outs),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------------------
    // Failure reporting
    // ----------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // Per-cycle sampling, mid-cycle after the falling-edge drive
    // ----------------------------------------------------------------------
    task automatic sample_cycle();
        // Held output must survive the stall
        if (stalled) begin
            check("outs_valid", outs_valid, 1'b1);
            check("outs", outs, held_outs);
        end
        // Input accepted at the coming rising edge
        if (ins_valid && ins_ready) begin
            expected.push_back(fptosi_model(ins));
            sent++;
        end
        hold_in = ins_valid && !ins_ready;
        // Output taken at the coming rising edge
        if (outs_valid && outs_ready) begin
            if (expected.size() == 0) begin
                fail_run("Output transfer seen with no input left to match it");
            end
            check("outs", outs, expected.pop_front());
        end
        stalled   = outs_valid && !outs_ready;
        held_outs = outs;
    endtask

    // Isolated input, outs_ready high, count rising edges to outs_valid
    task automatic measure_latency(input logic [31:0] value);
        int   edges;
        logic got_valid;
        edges = 0;
        @(negedge clk);
        ins        = value;
        ins_valid  = 1'b1;
        outs_ready = 1'b1;
        #1;
        check("ins_ready", ins_ready, 1'b1);
        sample_cycle();
        forever begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            ins_valid = 1'b0;
            #1;
            got_valid = outs_valid;
            sample_cycle();
            if (got_valid) break;
            if (edges >= 4 * fptosi_pkg::LATENCY) begin
                fail_run("Isolated input never reached the output");
            end
        end
        check("latency_edges", edges, fptosi_pkg::LATENCY);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int waited;
        clk        = 1'b0;
        rst        = 1'b1;
        ins        = '0;
        ins_valid  = 1'b0;
        outs_ready = 1'b0;
        sent       = 0;
        hold_in    = 1'b0;
        stalled    = 1'b0;
        held_outs  = '0;
        void'($urandom(32'h6e13_3a95));

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        // Idle state straight out of reset
        check("outs_valid", outs_valid, 1'b0);
        check("ins_ready", ins_ready, 1'b1);

        // Latency, positive and negative operand
        measure_latency(32'h449A_4000);
        measure_latency(32'hC2F6_E979);
        sent = 0;

        // Random traffic with back-pressure
        while (sent < N_OPS) begin
            @(negedge clk);
            if (!hold_in) begin
                ins_valid = ($urandom_range(99, 0) < 70);
                ins       = gen_operand();
            end
            outs_ready = ($urandom_range(99, 0) < 60);
            #1;
            sample_cycle();
        end

        // Drain, no new inputs
        waited = 0;
        while (expected.size() != 0 && waited < 8 * fptosi_pkg::LATENCY) begin
            @(negedge clk);
            ins_valid  = 1'b0;
            outs_ready = 1'b1;
            #1;
            sample_cycle();
            waited++;
        end

        // Nothing extra may appear afterwards
        repeat (fptosi_pkg::LATENCY + 2) begin
            @(negedge clk);
            #1;
            sample_cycle();
        end

        if (expected.size() != 0) begin
            fail_run($sformatf("%0d results never came out", expected.size()));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        fail_run("Timeout: the run took longer than its time budget");
    end

endmodule

/* verilog/fptosi.sv */
module fptosi (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [fptosi_pkg::WIDTH-1:0] ins,
    input  logic                         ins_valid,
    output logic                         ins_ready,
    output logic [fptosi_pkg::WIDTH-1:0] outs,
    output logic                         outs_valid,
    input  logic                         outs_ready
);

    // ----------------------------------------------------------------------
    // Combinational unpack and convert
    // ----------------------------------------------------------------------
    logic                                  sign;
    fptosi_pkg::conv_class_e               conv_class;
    logic [fptosi_pkg::FRAC_W:0]           mantissa;
    logic signed [fptosi_pkg::SHIFT_W-1:0] shift;
    logic [fptosi_pkg::WIDTH-1:0]          converted;

    // Pipeline control
    logic                                  advance;
    logic                                  last_valid;

    // Data stages with index 0 nearest the converter
    logic [fptosi_pkg::WIDTH-1:0]          stage_q [fptosi_pkg::PIPE_STAGES];

    fp_unpack u_unpack (
        .ins        (ins),
        .sign       (sign),
        .conv_class (conv_class),
        .mantissa   (mantissa),
        .shift      (shift)
    );

    fp_int_convert u_convert (
        .sign       (sign),
        .conv_class (conv_class),
        .mantissa   (mantissa),
        .shift      (shift),
        .converted  (converted)
    );

    // ----------------------------------------------------------------------
    // Enabled data stages
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fptosi_pkg::PIPE_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else if (advance) begin
            // All stages move together, bubbles included
            stage_q[0] <= converted;
            for (int i = 1; i < fptosi_pkg::PIPE_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Valid line beside the data stages
    delay_buffer #(
        .SIZE (fptosi_pkg::PIPE_STAGES)
    ) u_valid_line (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (ins_valid),
        .ready_in  (advance),
        .valid_out (last_valid)
    );

    // ----------------------------------------------------------------------
    // Output buffer
    // ----------------------------------------------------------------------
    oehb u_out_buf (
        .clk        (clk),
        .rst        (rst),
        .ins        (stage_q[fptosi_pkg::PIPE_STAGES-1]),
        .ins_valid  (last_valid),
        .ins_ready  (advance),
        .outs       (outs),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

    // Whole pipeline stalls with the buffer
    assign ins_ready = advance;

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    // Handshake must be driven once out of reset
    valid_known_a: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(ins_valid)
    ) else $error("fptosi: ins_valid unknown");

endmodule

/* verilog/oehb.sv */
module oehb (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [fptosi_pkg::WIDTH-1:0] ins,
    input  logic                         ins_valid,
    output logic                         ins_ready,
    output logic [fptosi_pkg::WIDTH-1:0] outs,
    output logic                         outs_valid,
    input  logic                         outs_ready
);

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    // One entry plus occupancy
    logic                         full;
    logic [fptosi_pkg::WIDTH-1:0] data_q;

    // Room when empty, or when the held entry leaves this cycle
    assign ins_ready = !full || outs_ready;

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (ins_ready) begin
            // Reload or drain in one step
            full <= ins_valid;
        end
    end

    // Payload only written on an accepted item
    always_ff @(posedge clk) begin
        if (ins_valid && ins_ready) begin
            data_q <= ins;
        end
    end

    assign outs       = data_q;
    assign outs_valid = full;

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    // Offered result stays put until taken
    stall_stable_a: assert property (
        @(posedge clk) disable iff (rst)
        (outs_valid && !outs_ready) |=> (outs_valid && $stable(outs))
    ) else $error("oehb: output changed under back-pressure");

endmodule

/* verilog/delay_buffer.sv */
module delay_buffer #(
    parameter int SIZE = fptosi_pkg::PIPE_STAGES
) (
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    input  logic ready_in,
    output logic valid_out
);

    // ----------------------------------------------------------------------
    // Valid shift register
    // ----------------------------------------------------------------------

    // Bit i follows data stage i
    logic [SIZE-1:0] valid_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else if (ready_in) begin
            // Bubbles move too, whole line shifts as one
            valid_sr[0] <= valid_in;
            for (int i = 1; i < SIZE; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    // Last stage feeds the output buffer
    assign valid_out = valid_sr[SIZE-1];

    // Stalled line must not move
    hold_on_stall_a: assert property (
        @(posedge clk) disable iff (rst)
        !ready_in |=> $stable(valid_out)
    ) else $error("delay_buffer: valid_out moved while stalled");

endmodule

/* verilog/fp_int_convert.sv */
module fp_int_convert (
    input  logic                                  sign,
    input  fptosi_pkg::conv_class_e               conv_class,
    input  logic [fptosi_pkg::FRAC_W:0]           mantissa,
    input  logic signed [fptosi_pkg::SHIFT_W-1:0] shift,
    output logic [fptosi_pkg::WIDTH-1:0]          converted
);

    // ----------------------------------------------------------------------
    // Mantissa alignment
    // ----------------------------------------------------------------------

    // Mantissa widened to the result word
    logic [fptosi_pkg::WIDTH-1:0]   mant_ext;

    // Shift distance without sign
    logic [fptosi_pkg::SHIFT_W-1:0] shift_mag;

    // Unsigned integer part before the sign is applied
    logic [fptosi_pkg::WIDTH-1:0]   magnitude;

    assign mant_ext = {{(fptosi_pkg::WIDTH - fptosi_pkg::FRAC_W - 1){1'b0}}, mantissa};

    // Negative shift means right shift by its magnitude
    assign shift_mag = shift[fptosi_pkg::SHIFT_W-1] ? $unsigned(-shift)
                                                     : $unsigned(shift);

    // Right shift drops fraction bits, which is the truncation
    // Left shift stops at +7 so bit 31 stays clear
    assign magnitude = shift[fptosi_pkg::SHIFT_W-1] ? (mant_ext >> shift_mag)
                                                     : (mant_ext << shift_mag);

    // ----------------------------------------------------------------------
    // Result select
    // ----------------------------------------------------------------------
    always_comb begin
        case (conv_class)
            fptosi_pkg::CLS_ZERO,
            fptosi_pkg::CLS_FRACTION: begin
                // Truncates to zero, sign dropped
                converted = '0;
            end
            fptosi_pkg::CLS_SATURATE: begin
                // Clamp by sign bit, NaN included
                converted = sign ? fptosi_pkg::INT_MIN : fptosi_pkg::INT_MAX;
            end
            fptosi_pkg::CLS_NORMAL: begin
                // Two's complement negate
                converted = sign ? (~magnitude + 1'b1) : magnitude;
            end
            default: begin
                converted = '0;
            end
        endcase
    end

endmodule

/* verilog/fp_unpack.sv */
module fp_unpack (
    input  logic [fptosi_pkg::WIDTH-1:0]          ins,
    output logic                                  sign,
    output fptosi_pkg::conv_class_e               conv_class,
    output logic [fptosi_pkg::FRAC_W:0]           mantissa,
    output logic signed [fptosi_pkg::SHIFT_W-1:0] shift
);

    // ----------------------------------------------------------------------
    // Field split
    // ----------------------------------------------------------------------
    logic [fptosi_pkg::EXP_W-1:0]         exp_field;
    logic [fptosi_pkg::FRAC_W-1:0]        frac_field;

    // Two guard bits so -127 .. +128 fits signed
    logic signed [fptosi_pkg::EXP_W+1:0]  exp_unb;
    logic signed [fptosi_pkg::EXP_W+1:0]  shift_full;

    assign sign       = ins[fptosi_pkg::WIDTH-1];
    assign exp_field  = ins[fptosi_pkg::WIDTH-2 -: fptosi_pkg::EXP_W];
    assign frac_field = ins[fptosi_pkg::FRAC_W-1:0];

    // Unbiased exponent
    assign exp_unb = $signed({2'b00, exp_field})
                   - (fptosi_pkg::EXP_W + 2)'(fptosi_pkg::EXP_BIAS);

    // Hidden one only for nonzero exponent
    assign mantissa = {exp_field != '0, frac_field};

    // Positive means shift left, negative means shift right
    assign shift_full = exp_unb - (fptosi_pkg::EXP_W + 2)'(fptosi_pkg::FRAC_W);

    // ----------------------------------------------------------------------
    // Classification
    // ----------------------------------------------------------------------
    always_comb begin
        // Priority: zero, saturate, fraction, normal
        if (exp_field == '0 && frac_field == '0) begin
            conv_class = fptosi_pkg::CLS_ZERO;
        end else if (exp_unb > (fptosi_pkg::EXP_W + 2)'(fptosi_pkg::MAX_EXP)) begin
            // Also catches all-ones exponent, inf and NaN
            conv_class = fptosi_pkg::CLS_SATURATE;
        end else if (exp_unb < 0) begin
            // Subnormals land here with exponent -127
            conv_class = fptosi_pkg::CLS_FRACTION;
        end else begin
            conv_class = fptosi_pkg::CLS_NORMAL;
        end
    end

    // Shift only meaningful for the normal class, range -23 .. +7
    assign shift = (conv_class == fptosi_pkg::CLS_NORMAL)
                 ? $signed(shift_full[fptosi_pkg::SHIFT_W-1:0])
                 : '0;

    // Known operand must always yield a known class
    class_known_a: assert final ($isunknown(ins) || !$isunknown(conv_class))
        else $error("fp_unpack: unknown class for operand %h", ins);

endmodule

/* verilog/fptosi_pkg.sv */
package fptosi_pkg;

    // ----------------------------------------------------------------------
    // Word and IEEE-754 single-precision field sizes
    // ----------------------------------------------------------------------

    // Data word on both channels
    localparam int WIDTH = 32;

    // Exponent and fraction fields
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;

    // Exponent bias for single precision
    localparam int EXP_BIAS = 127;

    // Largest unbiased exponent whose magnitude still fits a signed word
    localparam int MAX_EXP = 30;

    // Signed mantissa shift, covers -23 up to +7
    localparam int SHIFT_W = 6;

    // ----------------------------------------------------------------------
    // Pipeline timing
    // ----------------------------------------------------------------------

    // Enabled data stages between converter and output buffer
    localparam int PIPE_STAGES = 4;

    // Accept to outs_valid, counted in rising edges, no back-pressure
    localparam int LATENCY = PIPE_STAGES + 1;

    // ----------------------------------------------------------------------
    // Saturation results
    // ----------------------------------------------------------------------
    localparam logic [WIDTH-1:0] INT_MAX = 32'h7FFF_FFFF;
    localparam logic [WIDTH-1:0] INT_MIN = 32'h8000_0000;

    // Operand class, decides the conversion path
    typedef enum logic [1:0] {
        CLS_ZERO,       // exact zero of either sign
        CLS_FRACTION,   // subnormal or magnitude below one
        CLS_NORMAL,     // in-range, needs the mantissa shift
        CLS_SATURATE    // too large, infinity or NaN
    } conv_class_e;

endpackage
